//--- color_mapper.sv
// Color mapper that bands escape counts into RGB332 and sends pixels under sink credit control
`timescale 1ns/1ns

module color_mapper import mandel_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  iter_t       frame_max_iter,
	count_if.mapper     cnt,
	input  logic        credit_return,
	output logic        pixel_valid,
	output pixel_addr_t pixel_addr,
	output color_t      pixel_color,
	output logic        frame_done
);

	// Output register
	logic        hold_q;
	pixel_addr_t addr_q;
	color_t      color_q;
	logic        last_q;
	// Free slots in the sink
	credit_t     credit_q;
	color_t      color_next;
	logic        take;
	logic        send;

	// Band lookup, lowest matching band wins
	always_comb begin
		color_next = PALETTE[BANDS];
		for (int k = BANDS; k >= 0; k--) begin
			if (cnt.count >= (frame_max_iter >> k)) begin
				color_next = PALETTE[k];
			end
		end
	end

	assign take = cnt.valid && cnt.ready;
	// Held pixel goes out on the first cycle with a credit
	assign send = hold_q && (credit_q != '0);

	//////////////////////////////////////////////////
	// Control and credits
	//////////////////////////////////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hold_q   <= 1'b0;
			credit_q <= credit_t'(CREDIT_MAX);
		end else begin
			if (take) begin
				hold_q <= 1'b1;
			end else if (send) begin
				hold_q <= 1'b0;
			end
			// Send and return together leave the count as is
			case ({send, credit_return})
				2'b10:   credit_q <= credit_q - 1'b1;
				2'b01:   credit_q <= credit_q + 1'b1;
				default: credit_q <= credit_q;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			addr_q  <= cnt.addr;
			color_q <= color_next;
			last_q  <= cnt.last;
		end
	end

	// Stall backs up into the iterator while full
	assign cnt.ready   = !hold_q;
	assign pixel_valid = send;
	assign pixel_addr  = addr_q;
	assign pixel_color = color_q;
	assign frame_done  = send && last_q;

endmodule

//--- coord_walker.sv
// Frame walker that latches the view on start and issues one point per pixel in raster order
`timescale 1ns/1ns

module coord_walker import mandel_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   start,
	input  fixed_t cr_start,
	input  fixed_t ci_start,
	input  fixed_t dx,
	input  fixed_t dy,
	input  iter_t  max_iter,
	input  logic   frame_done,
	output logic   busy,
	output iter_t  frame_max_iter,
	point_if.walker pts
);

	// Raster position, x fastest
	logic [$clog2(FRAME_W)-1:0] x_q;
	logic [$clog2(FRAME_H)-1:0] y_q;
	logic   valid_q;
	// View latched at start
	fixed_t cr_base_q;
	fixed_t dx_q;
	fixed_t dy_q;
	iter_t  max_iter_q;
	// Running coordinate of the current point
	fixed_t cr_q;
	fixed_t ci_q;
	logic   launch;
	logic   advance;
	logic   row_end;

	// Start is ignored mid-frame
	assign launch  = start && !busy;
	assign advance = pts.valid && pts.ready;
	assign row_end = (x_q == FRAME_W - 1);

	//////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy    <= 1'b0;
			valid_q <= 1'b0;
			x_q     <= '0;
			y_q     <= '0;
		end else if (launch) begin
			busy    <= 1'b1;
			valid_q <= 1'b1;
			x_q     <= '0;
			y_q     <= '0;
		end else begin
			// Busy holds until the last pixel leaves the mapper
			if (frame_done) begin
				busy <= 1'b0;
			end
			if (advance) begin
				if (pts.last) begin
					valid_q <= 1'b0;
				end else if (row_end) begin
					x_q <= '0;
					y_q <= y_q + 1'b1;
				end else begin
					x_q <= x_q + 1'b1;
				end
			end
		end
	end

	// Coordinate sums, wrap in fixed_t
	always_ff @(posedge clk) begin
		if (launch) begin
			cr_base_q  <= cr_start;
			dx_q       <= dx;
			dy_q       <= dy;
			max_iter_q <= max_iter;
			cr_q       <= cr_start;
			ci_q       <= ci_start;
		end else if (advance && !pts.last) begin
			if (row_end) begin
				// New row, imaginary part walks down
				cr_q <= cr_base_q;
				ci_q <= ci_q - dy_q;
			end else begin
				cr_q <= cr_q + dx_q;
			end
		end
	end

	assign pts.valid = valid_q;
	assign pts.cr    = cr_q;
	assign pts.ci    = ci_q;
	// FRAME_W is a power of two so the concatenation is y * FRAME_W + x
	assign pts.addr  = {y_q, x_q};
	assign pts.last  = ({y_q, x_q} == FRAME_PIXELS - 1);
	assign frame_max_iter = max_iter_q;

endmodule

//--- count_if.sv
// Handshake bundle carrying one escape count and its pixel address from iterator to mapper
`timescale 1ns/1ns

interface count_if import mandel_pkg::*; ();

	logic        valid;
	logic        ready;
	iter_t       count;
	pixel_addr_t addr;
	logic        last;

	modport iterator (
		output valid, count, addr, last,
		input  ready
	);

	modport mapper (
		input  valid, count, addr, last,
		output ready
	);

endinterface

//--- escape_iterator.sv
// Escape iterator that runs z = z^2 + c on one point at a time, one step per clock
`timescale 1ns/1ns

module escape_iterator import mandel_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  iter_t frame_max_iter,
	point_if.iterator pts,
	count_if.iterator cnt
);

	typedef enum logic [1:0] {
		IDLE,
		CALC,
		HOLD
	} state_t;

	state_t      state_q;
	// Point under test
	fixed_t      cr_q;
	fixed_t      ci_q;
	pixel_addr_t addr_q;
	logic        last_q;
	// Orbit and step count
	fixed_t      zr_q;
	fixed_t      zi_q;
	iter_t       n_q;
	fixed_t      zr_next;
	fixed_t      zi_next;
	iter_t       n_next;
	logic        stop;
	logic        accept;

	//////////////////////////////////////////////////
	// One recurrence step
	//////////////////////////////////////////////////
	always_comb begin
		// zr' = zr^2 - zi^2 + cr
		zr_next = fixed_mul(zr_q, zr_q) - fixed_mul(zi_q, zi_q) + cr_q;
		// zi' = 2 zr zi + ci
		zi_next = (fixed_mul(zr_q, zi_q) <<< 1) + ci_q;
		n_next  = n_q + 1'b1;
		// Escape is judged on the new z
		stop    = escaped(zr_next, zi_next) || (n_next >= frame_max_iter);
	end

	// Takes a point only when idle
	assign accept = pts.valid && pts.ready;

	//////////////////////////////////////////////////
	// FSM
	//////////////////////////////////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q <= IDLE;
		end else begin
			case (state_q)
				IDLE: begin
					if (accept) begin
						state_q <= CALC;
					end
				end
				CALC: begin
					if (stop) begin
						state_q <= HOLD;
					end
				end
				HOLD: begin
					// Result stays up until the mapper takes it
					if (cnt.ready) begin
						state_q <= IDLE;
					end
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	// Datapath
	always_ff @(posedge clk) begin
		if (accept) begin
			cr_q   <= pts.cr;
			ci_q   <= pts.ci;
			addr_q <= pts.addr;
			last_q <= pts.last;
			// Orbit starts at the origin
			zr_q   <= '0;
			zi_q   <= '0;
			n_q    <= '0;
		end else if (state_q == CALC) begin
			zr_q <= zr_next;
			zi_q <= zi_next;
			n_q  <= n_next;
		end
	end

	assign pts.ready = (state_q == IDLE);
	assign cnt.valid = (state_q == HOLD);
	// n_q already holds the final step count in HOLD
	assign cnt.count = n_q;
	assign cnt.addr  = addr_q;
	assign cnt.last  = last_q;

endmodule

//--- files.f
mandel_pkg.sv
point_if.sv
count_if.sv
coord_walker.sv
escape_iterator.sv
color_mapper.sv
mandel_engine.sv
tb_mandel_engine.sv

//--- mandel_engine.sv
// Top of the escape-time engine joining walker, iterator and mapper behind plain ports
`timescale 1ns/1ns

module mandel_engine import mandel_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        start,
	input  fixed_t      cr_start,
	input  fixed_t      ci_start,
	input  fixed_t      dx,
	input  fixed_t      dy,
	input  iter_t       max_iter,
	input  logic        credit_return,
	output logic        busy,
	output logic        pixel_valid,
	output pixel_addr_t pixel_addr,
	output color_t      pixel_color,
	output logic        frame_done
);

	// Limit latched for the whole frame
	iter_t frame_max_iter;

	point_if pts_if ();
	count_if cnt_if ();

	// Decode
	coord_walker u_walker (
		.clk            (clk),
		.rst            (rst),
		.start          (start),
		.cr_start       (cr_start),
		.ci_start       (ci_start),
		.dx             (dx),
		.dy             (dy),
		.max_iter       (max_iter),
		.frame_done     (frame_done),
		.busy           (busy),
		.frame_max_iter (frame_max_iter),
		.pts            (pts_if)
	);

	// Execute
	escape_iterator u_iterator (
		.clk            (clk),
		.rst            (rst),
		.frame_max_iter (frame_max_iter),
		.pts            (pts_if),
		.cnt            (cnt_if)
	);

	// Result
	color_mapper u_mapper (
		.clk            (clk),
		.rst            (rst),
		.frame_max_iter (frame_max_iter),
		.cnt            (cnt_if),
		.credit_return  (credit_return),
		.pixel_valid    (pixel_valid),
		.pixel_addr     (pixel_addr),
		.pixel_color    (pixel_color),
		.frame_done     (frame_done)
	);

endmodule

//--- mandel_pkg.sv
// Shared fixed-point types, frame geometry, credit sizing and palette for the escape-time engine
package mandel_pkg;

	//////////////////////////////////////////////////
	// Fixed point, signed 4.23
	//////////////////////////////////////////////////
	localparam int FIXED_W = 27;
	localparam int FRAC_BITS = 23;

	typedef logic signed [FIXED_W-1:0] fixed_t;
	// Room for a full product plus one carry
	typedef logic signed [2*FIXED_W:0] wide_t;

	// 4.0, compared against |z|^2
	localparam fixed_t ESCAPE_LIMIT = fixed_t'(4 << FRAC_BITS);

	// Iteration counts and user limit
	typedef logic [9:0] iter_t;

	// RGB332
	typedef logic [7:0] color_t;

	//////////////////////////////////////////////////
	// Frame and output flow control
	//////////////////////////////////////////////////
	localparam int FRAME_W = 16;
	localparam int FRAME_H = 8;
	localparam int FRAME_PIXELS = FRAME_W * FRAME_H;

	// y * FRAME_W + x
	typedef logic [$clog2(FRAME_PIXELS)-1:0] pixel_addr_t;

	// Pixel slots in the sink
	localparam int CREDIT_MAX = 4;
	localparam int CREDIT_W = $clog2(CREDIT_MAX + 1);
	typedef logic [CREDIT_W-1:0] credit_t;

	// Threshold bands, band 0 is the set itself
	localparam int BANDS = 8;
	localparam color_t PALETTE [0:BANDS] = '{
		8'b000_000_00,
		8'b011_001_00,
		8'b011_001_00,
		8'b101_010_01,
		8'b011_001_01,
		8'b001_001_01,
		8'b011_010_10,
		8'b010_100_10,
		8'b010_100_10
	};

	// Full product, back to 4.23, wraps on overflow
	function automatic fixed_t fixed_mul(fixed_t a, fixed_t b);
		wide_t prod;
		prod = wide_t'(a) * wide_t'(b);
		return fixed_t'(prod >>> FRAC_BITS);
	endfunction

	// Escape test on |z|^2, squares kept wide so large z cannot wrap
	function automatic logic escaped(fixed_t zr, fixed_t zi);
		wide_t mag;
		mag = wide_t'(zr) * wide_t'(zr) + wide_t'(zi) * wide_t'(zi);
		return (mag >>> FRAC_BITS) > wide_t'(ESCAPE_LIMIT);
	endfunction

endpackage

//--- point_if.sv
// Handshake bundle carrying one complex point and its pixel address from walker to iterator
`timescale 1ns/1ns

interface point_if import mandel_pkg::*; ();

	logic        valid;
	logic        ready;
	// Point c in the complex plane
	fixed_t      cr;
	fixed_t      ci;
	pixel_addr_t addr;
	// Final point of the frame
	logic        last;

	modport walker (
		output valid, cr, ci, addr, last,
		input  ready
	);

	modport iterator (
		input  valid, cr, ci, addr, last,
		output ready
	);

endinterface

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_mandel_engine -f files.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi
echo "Simulation finished without failure"

//--- tb_mandel_engine.sv
// Directed testbench for the escape-time engine, compiled from files.f and run as the top module
`timescale 1ns/1ns

module tb_mandel_engine import mandel_pkg::*; ();

	// Six frames of 128 pixels at up to 66 cycles each plus slack
	localparam int CYCLE_LIMIT = 60000;
	localparam int SINK_PROMPT = 0;
	localparam int SINK_HOLD = 1;
	localparam int SINK_RANDOM = 2;

	logic        clk;
	logic        rst;
	logic        start;
	fixed_t      cr_start;
	fixed_t      ci_start;
	fixed_t      dx;
	fixed_t      dy;
	iter_t       max_iter;
	logic        credit_return;
	logic        busy;
	logic        pixel_valid;
	pixel_addr_t pixel_addr;
	color_t      pixel_color;
	logic        frame_done;

	// Expected and received frame
	color_t      exp_color [FRAME_PIXELS];
	color_t      got_color [FRAME_PIXELS];
	string       test_name;
	int          next_addr;
	int          rx_count;
	int          done_count;
	int          base_done;
	// Credits held by the sink, and credits not yet sent back
	int          outstanding;
	int          owed;
	int          wait_left;
	int          sink_mode;
	logic [15:0] lfsr_q;
	int          mismatches;
	int          failures;
	int          cycles;

	mandel_engine dut0 (
		.clk           (clk),
		.rst           (rst),
		.start         (start),
		.cr_start      (cr_start),
		.ci_start      (ci_start),
		.dx            (dx),
		.dy            (dy),
		.max_iter      (max_iter),
		.credit_return (credit_return),
		.busy          (busy),
		.pixel_valid   (pixel_valid),
		.pixel_addr    (pixel_addr),
		.pixel_color   (pixel_color),
		.frame_done    (frame_done)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Helpers and reference model
	//////////////////////////////////////////////////
	task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
			mismatches++;
		end
	endtask

	task automatic report_counts();
		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
	endtask

	// Galois LFSR stepped once per bit taken
	function automatic int rand_bits(int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | lfsr_q[0];
			lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
		end
		return v;
	endfunction

	// Thousandths to 4.23
	function automatic fixed_t from_milli(int m);
		return fixed_t'((longint'(m) <<< FRAC_BITS) / 1000);
	endfunction

	function automatic iter_t escape_count(fixed_t cr, fixed_t ci, iter_t m);
		fixed_t zr;
		fixed_t zi;
		fixed_t tr;
		fixed_t ti;
		iter_t  n;
		longint mag;
		logic   done;
		zr = '0;
		zi = '0;
		n = '0;
		done = 1'b0;
		while (!done) begin
			tr = fixed_mul(zr, zr) - fixed_mul(zi, zi) + cr;
			// Doubling wraps in 27 bits
			ti = fixed_t'(fixed_mul(zr, zi) * 2) + ci;
			zr = tr;
			zi = ti;
			n = n + 1'b1;
			mag = (longint'(zr) * longint'(zr) + longint'(zi) * longint'(zi)) >>> FRAC_BITS;
			done = (mag > longint'(ESCAPE_LIMIT)) || (n >= m);
		end
		return n;
	endfunction

	// First matching threshold band
	function automatic color_t band_color(iter_t count, iter_t m);
		color_t c;
		logic   found;
		c = PALETTE[8];
		found = (count >= m);
		if (found) c = 8'h00;
		for (int k = 1; k <= 8; k++) begin
			if (!found && count >= (m >> k)) begin
				c = PALETTE[k];
				found = 1'b1;
			end
		end
		return c;
	endfunction

	task automatic build_model(fixed_t cr0, fixed_t ci0, fixed_t ddx, fixed_t ddy, iter_t m);
		fixed_t cr;
		fixed_t ci;
		cr = cr0;
		ci = ci0;
		for (int p = 0; p < FRAME_PIXELS; p++) begin
			exp_color[p] = band_color(escape_count(cr, ci, m), m);
			// Running sums as the walker keeps them
			if (p % FRAME_W == FRAME_W - 1) begin
				cr = cr0;
				ci = ci - ddy;
			end else begin
				cr = cr + ddx;
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Pixel monitor and credit sink
	//////////////////////////////////////////////////
	always @(negedge clk) begin
		if (pixel_valid) begin
			check_value({test_name, " addr"}, next_addr, pixel_addr);
			check_value({test_name, " color"}, exp_color[next_addr], pixel_color);
			check_value({test_name, " frame_done"}, next_addr == FRAME_PIXELS - 1, frame_done);
			got_color[pixel_addr] = pixel_color;
			next_addr++;
			rx_count++;
			owed++;
			outstanding++;
			if (outstanding > CREDIT_MAX) begin
				$display("ERROR %s: pixel sent with no credit left", test_name);
				failures++;
			end
		end
		if (frame_done) begin
			done_count++;
		end
	end

	always @(posedge clk) begin
		// Return driven last cycle lands in the DUT at this edge
		if (credit_return) outstanding--;
		#10;
		credit_return = 1'b0;
		if (sink_mode != SINK_HOLD && owed > 0) begin
			if (wait_left == 0) begin
				credit_return = 1'b1;
				owed--;
				// Delays up to 127 cycles so the credit pool drains
				if (sink_mode == SINK_RANDOM) wait_left = rand_bits(7);
			end else begin
				wait_left--;
			end
		end
	end

	//////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////
	task automatic tick();
		@(posedge clk);
		#10;
	endtask

	task automatic set_sink_mode(int m);
		@(negedge clk);
		sink_mode = m;
		wait_left = 0;
	endtask

	task automatic start_frame(string name, int cr0, int ci0, int ddx, int ddy, int m);
		test_name = name;
		build_model(from_milli(cr0), from_milli(ci0), from_milli(ddx), from_milli(ddy), iter_t'(m));
		next_addr = 0;
		rx_count = 0;
		base_done = done_count;
		tick();
		cr_start = from_milli(cr0);
		ci_start = from_milli(ci0);
		dx = from_milli(ddx);
		dy = from_milli(ddy);
		max_iter = iter_t'(m);
		start = 1'b1;
		tick();
		start = 1'b0;
		check_value({name, " busy rise"}, 1, busy);
	endtask

	task automatic finish_frame();
		while (done_count == base_done) tick();
		check_value({test_name, " busy fall"}, 0, busy);
		check_value({test_name, " pixel count"}, FRAME_PIXELS, rx_count);
		// Let all credits come home before the next frame
		while (outstanding != 0) tick();
		check_value({test_name, " frame_done count"}, 1, done_count - base_done);
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////
	task automatic test_reset_state();
		@(negedge clk);
		check_value("reset busy", 0, busy);
		check_value("reset pixel_valid", 0, pixel_valid);
		check_value("reset frame_done", 0, frame_done);
	endtask

	task automatic test_full_frame();
		start_frame("full_frame", -2000, 1000, 156, 250, 64);
		finish_frame();
	endtask

	task automatic test_back_pressure();
		set_sink_mode(SINK_HOLD);
		start_frame("back_pressure", -1500, 600, 100, 150, 16);
		repeat (400) tick();
		check_value("back_pressure stalled count", CREDIT_MAX, rx_count);
		set_sink_mode(SINK_PROMPT);
		finish_frame();
	endtask

	task automatic test_limit_edges();
		start_frame("limit_inside", -100, 50, 10, 10, 4);
		finish_frame();
		for (int p = 0; p < FRAME_PIXELS; p++) begin
			check_value("limit_inside black", 8'h00, got_color[p]);
		end
		// Far outside so every point escapes on the first step
		start_frame("escape_first", 3000, 500, 10, 100, 4);
		finish_frame();
		for (int p = 0; p < FRAME_PIXELS; p++) begin
			check_value("escape_first band", band_color(iter_t'(1), iter_t'(4)), got_color[p]);
		end
	endtask

	task automatic test_start_while_busy();
		start_frame("start_busy", -800, 300, 40, 60, 32);
		while (rx_count < 20) tick();
		cr_start = from_milli(500);
		max_iter = iter_t'(8);
		start = 1'b1;
		tick();
		start = 1'b0;
		finish_frame();
		repeat (20) tick();
		check_value("start_busy total frame_done", 1, done_count - base_done);
	endtask

	task automatic test_random_credits();
		set_sink_mode(SINK_RANDOM);
		start_frame("random_credits", -1000, 400, 30, 50, 32);
		finish_frame();
		set_sink_mode(SINK_PROMPT);
	endtask

	// Watchdog
	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("ERROR timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		report_counts();
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		rst = 1'b1;
		start = 1'b0;
		cr_start = '0;
		ci_start = '0;
		dx = '0;
		dy = '0;
		max_iter = '0;
		credit_return = 1'b0;
		lfsr_q = 16'd21;
		sink_mode = SINK_PROMPT;
		test_name = "reset";
		next_addr = 0;
		rx_count = 0;
		done_count = 0;
		base_done = 0;
		outstanding = 0;
		owed = 0;
		wait_left = 0;
		mismatches = 0;
		failures = 0;
		repeat (3) @(posedge clk);
		#10;
		rst = 1'b0;
		test_reset_state();
		test_full_frame();
		test_back_pressure();
		test_limit_edges();
		test_start_while_busy();
		test_random_credits();
		report_counts();
		if (mismatches == 0 && failures == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
